// File: flist.f
+incdir+src
src/usb_tx_pkg.sv
src/usb_tx_byte_if.sv
src/usb_tx_pid_decode.sv
src/usb_tx_sequencer.sv
src/usb_tx_line_encoder.sv
src/usb_tx.sv
verification/usb_tx_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module usb_tx_tb -o usb_tx_sim \
        > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/usb_tx_sim > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || grep -q "TEST PASS" sim.log

// File: src/usb_tx.sv
`timescale 1ns/10ps
`default_nettype none

module usb_tx (
        input wire logic clk,
        input wire logic arst_n,
        input wire usb_tx_pkg::tx_req_t tx_packet,
        input wire usb_tx_pkg::usb_byte_t tx_packet_data,
        input wire usb_tx_pkg::pkt_size_t tx_packet_data_size,
        output logic get_data,
        output logic busy,
        output logic tx_done,
        output logic dp,
        output logic dm
);

        logic start;
        usb_tx_pkg::usb_byte_t pid;
        usb_tx_pkg::pkt_kind_t kind;
        usb_tx_pkg::pkt_size_t size;

        usb_tx_byte_if byte_bus ();

        // request capture and pid lookup
        usb_tx_pid_decode u_decode (
                .clk                 (clk),
                .arst_n              (arst_n),
                .tx_packet           (tx_packet),
                .tx_packet_data_size (tx_packet_data_size),
                .done                (tx_done),
                .start               (start),
                .pid                 (pid),
                .kind                (kind),
                .size                (size),
                .busy                (busy)
        );

        usb_tx_sequencer u_sequencer (
                .clk            (clk),
                .arst_n         (arst_n),
                .start          (start),
                .pid            (pid),
                .kind           (kind),
                .size           (size),
                .tx_packet_data (tx_packet_data),
                .get_data       (get_data),
                .done           (tx_done),
                .bus            (byte_bus)
        );

        usb_tx_line_encoder u_encoder (
                .clk    (clk),
                .arst_n (arst_n),
                .bus    (byte_bus),
                .dp     (dp),
                .dm     (dm)
        );

endmodule

`default_nettype wire

// File: src/usb_tx_byte_if.sv
`timescale 1ns/10ps
`default_nettype none

interface usb_tx_byte_if;

        usb_tx_pkg::usb_byte_t byte_data;
        logic byte_valid;
        logic byte_eop;
        // encoder took the byte or the eop
        logic byte_load;

        modport source (
                output byte_data,
                output byte_valid,
                output byte_eop,
                input byte_load
        );

        modport sink (
                input byte_data,
                input byte_valid,
                input byte_eop,
                output byte_load
        );

endinterface

`default_nettype wire

// File: src/usb_tx_config.svh
`ifndef USB_TX_CONFIG_SVH
`define USB_TX_CONFIG_SVH

// sync pattern KJKJKJKK, sent lsb first
`define USB_SYNC_BYTE 8'h80

// full pid bytes, check nibble in the upper half
`define USB_PID_DATA0 8'hC3
`define USB_PID_ACK 8'hD2
`define USB_PID_NAK 8'h5A

// crc16 in reflected form
`define USB_CRC16_POLY 16'hA001
`define USB_CRC16_SEED 16'hFFFF

// a zero goes in after this many ones
`define USB_STUFF_RUN 3'd6

`endif

// File: src/usb_tx_line_encoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "usb_tx_config.svh"

module usb_tx_line_encoder (
        input wire logic clk,
        input wire logic arst_n,
        usb_tx_byte_if.sink bus,
        output logic dp,
        output logic dm
);

        usb_tx_pkg::enc_state_t state;
        usb_tx_pkg::usb_byte_t shreg;
        // data bits of the current byte already on the line
        logic [3:0] bit_cnt;
        logic [2:0] ones_cnt;
        // previous line level, 1 is J
        logic last_level;
        logic stuff_now;
        logic level;
        logic empty;
        logic take_byte;

        assign stuff_now = (ones_cnt == `USB_STUFF_RUN);
        // nrzi: zero toggles, one keeps
        assign level = (!stuff_now && shreg[0]) ? last_level : ~last_level;

        // last line bit of this byte, trailing stuff bit included
        assign empty = (state == usb_tx_pkg::ENC_BITS) &&
                (stuff_now ? (bit_cnt == 4'd8) :
                 ((bit_cnt == 4'd7) && !(shreg[0] && (ones_cnt == `USB_STUFF_RUN - 3'd1))));

        assign take_byte = ((state == usb_tx_pkg::ENC_IDLE) || empty) && bus.byte_valid;
        assign bus.byte_load = take_byte ||
                ((state == usb_tx_pkg::ENC_J) && bus.byte_eop);

        always_comb begin
                case (state)
                        usb_tx_pkg::ENC_BITS: begin
                                dp = level;
                                dm = ~level;
                        end
                        usb_tx_pkg::ENC_SE0_1, usb_tx_pkg::ENC_SE0_2: begin
                                dp = 1'b0;
                                dm = 1'b0;
                        end
                        default: begin
                                dp = 1'b1;
                                dm = 1'b0;
                        end
                endcase
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        state <= usb_tx_pkg::ENC_IDLE;
                        bit_cnt <= '0;
                        ones_cnt <= '0;
                        last_level <= 1'b1;
                end else begin
                        last_level <= (state == usb_tx_pkg::ENC_BITS) ? level : 1'b1;
                        case (state)
                                usb_tx_pkg::ENC_IDLE: begin
                                        if (bus.byte_valid) begin
                                                state <= usb_tx_pkg::ENC_BITS;
                                                bit_cnt <= '0;
                                        end else if (bus.byte_eop) begin
                                                state <= usb_tx_pkg::ENC_SE0_1;
                                        end
                                end
                                usb_tx_pkg::ENC_BITS: begin
                                        if (stuff_now) begin
                                                ones_cnt <= '0;
                                        end else begin
                                                ones_cnt <= shreg[0] ? ones_cnt + 3'd1 : 3'd0;
                                                bit_cnt <= bit_cnt + 4'd1;
                                        end
                                        if (empty) begin
                                                if (bus.byte_valid) begin
                                                        bit_cnt <= '0;
                                                end else if (bus.byte_eop) begin
                                                        state <= usb_tx_pkg::ENC_SE0_1;
                                                end else begin
                                                        state <= usb_tx_pkg::ENC_IDLE;
                                                end
                                        end
                                end
                                usb_tx_pkg::ENC_SE0_1: begin
                                        state <= usb_tx_pkg::ENC_SE0_2;
                                        ones_cnt <= '0;
                                end
                                usb_tx_pkg::ENC_SE0_2: begin
                                        state <= usb_tx_pkg::ENC_J;
                                end
                                default: begin
                                        state <= usb_tx_pkg::ENC_IDLE;
                                end
                        endcase
                end
        end

        // stuff cycles leave the shift register alone
        always_ff @(posedge clk) begin
                if (take_byte) begin
                        shreg <= bus.byte_data;
                end else if ((state == usb_tx_pkg::ENC_BITS) && !stuff_now) begin
                        shreg <= shreg >> 1;
                end
        end

        a_no_se1: assert property (@(posedge clk) disable iff (!arst_n)
                !(dp && dm));

        a_ones_bound: assert property (@(posedge clk) disable iff (!arst_n)
                ones_cnt <= `USB_STUFF_RUN);

endmodule

`default_nettype wire

// File: src/usb_tx_pid_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "usb_tx_config.svh"

module usb_tx_pid_decode (
        input wire logic clk,
        input wire logic arst_n,
        input wire usb_tx_pkg::tx_req_t tx_packet,
        input wire usb_tx_pkg::pkt_size_t tx_packet_data_size,
        input wire logic done,
        output logic start,
        output usb_tx_pkg::usb_byte_t pid,
        output usb_tx_pkg::pkt_kind_t kind,
        output usb_tx_pkg::pkt_size_t size,
        output logic busy
);

        logic busy_r;
        logic accept;

        // busy already low in the done cycle
        assign busy = busy_r && !done;
        assign accept = !busy && (tx_packet != 2'd0);

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        busy_r <= 1'b0;
                        start <= 1'b0;
                end else begin
                        start <= accept;
                        if (accept) begin
                                busy_r <= 1'b1;
                        end else if (done) begin
                                busy_r <= 1'b0;
                        end
                end
        end

        // request code to pid byte and packet kind
        always_ff @(posedge clk) begin
                if (accept) begin
                        case (tx_packet)
                                2'd1: begin
                                        pid <= `USB_PID_DATA0;
                                        kind <= usb_tx_pkg::PKT_DATA;
                                        size <= tx_packet_data_size;
                                end
                                2'd2: begin
                                        pid <= `USB_PID_ACK;
                                        kind <= usb_tx_pkg::PKT_HANDSHAKE;
                                        size <= '0;
                                end
                                default: begin
                                        pid <= `USB_PID_NAK;
                                        kind <= usb_tx_pkg::PKT_HANDSHAKE;
                                        size <= '0;
                                end
                        endcase
                end
        end

        // start only on the rising edge of busy
        a_start_from_idle: assert property (@(posedge clk) disable iff (!arst_n)
                start |-> $rose(busy));

endmodule

`default_nettype wire

// File: src/usb_tx_pkg.sv
`default_nettype none

package usb_tx_pkg;

        // 0 none, 1 data0, 2 ack, 3 nak
        typedef logic [1:0] tx_req_t;

        typedef logic [7:0] usb_byte_t;
        typedef logic [15:0] usb_crc_t;
        typedef logic [6:0] pkt_size_t;

        typedef enum logic {
                PKT_DATA,
                PKT_HANDSHAKE
        } pkt_kind_t;

        typedef enum logic [2:0] {
                IDLE,
                SYNC,
                PID,
                DATA,
                CRC_LOW,
                CRC_HIGH,
                EOP
        } seq_state_t;

        typedef enum logic [2:0] {
                ENC_IDLE,
                ENC_BITS,
                ENC_SE0_1,
                ENC_SE0_2,
                ENC_J
        } enc_state_t;

endpackage

`default_nettype wire

// File: src/usb_tx_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "usb_tx_config.svh"

module usb_tx_sequencer (
        input wire logic clk,
        input wire logic arst_n,
        input wire logic start,
        input wire usb_tx_pkg::usb_byte_t pid,
        input wire usb_tx_pkg::pkt_kind_t kind,
        input wire usb_tx_pkg::pkt_size_t size,
        input wire usb_tx_pkg::usb_byte_t tx_packet_data,
        output logic get_data,
        output logic done,
        usb_tx_byte_if.source bus
);

        usb_tx_pkg::seq_state_t state;
        usb_tx_pkg::seq_state_t state_nxt;
        usb_tx_pkg::usb_byte_t data_nxt;
        usb_tx_pkg::usb_crc_t crc;
        // payload bytes still to fetch
        usb_tx_pkg::pkt_size_t count;
        logic fetch;

        // one byte into the crc, lsb first
        function automatic usb_tx_pkg::usb_crc_t crc16_byte(
                input usb_tx_pkg::usb_crc_t crc_in,
                input usb_tx_pkg::usb_byte_t data
        );
                usb_tx_pkg::usb_crc_t c;
                logic fb;
                c = crc_in;
                for (int i = 0; i < 8; i++) begin
                        fb = c[0] ^ data[i];
                        c = c >> 1;
                        if (fb) begin
                                c = c ^ `USB_CRC16_POLY;
                        end
                end
                return c;
        endfunction

        assign bus.byte_valid = (state != usb_tx_pkg::IDLE) && (state != usb_tx_pkg::EOP);
        assign bus.byte_eop = (state == usb_tx_pkg::EOP);

        always_comb begin
                state_nxt = state;
                data_nxt = bus.byte_data;
                fetch = 1'b0;
                case (state)
                        usb_tx_pkg::IDLE: begin
                                if (start) begin
                                        state_nxt = usb_tx_pkg::SYNC;
                                        data_nxt = `USB_SYNC_BYTE;
                                end
                        end
                        usb_tx_pkg::SYNC: begin
                                if (bus.byte_load) begin
                                        state_nxt = usb_tx_pkg::PID;
                                        data_nxt = pid;
                                end
                        end
                        // pid and data bytes share the payload decision
                        usb_tx_pkg::PID, usb_tx_pkg::DATA: begin
                                if (bus.byte_load) begin
                                        if (kind == usb_tx_pkg::PKT_HANDSHAKE) begin
                                                state_nxt = usb_tx_pkg::EOP;
                                        end else if (count != '0) begin
                                                state_nxt = usb_tx_pkg::DATA;
                                                data_nxt = tx_packet_data;
                                                fetch = 1'b1;
                                        end else begin
                                                state_nxt = usb_tx_pkg::CRC_LOW;
                                                data_nxt = ~crc[7:0];
                                        end
                                end
                        end
                        usb_tx_pkg::CRC_LOW: begin
                                if (bus.byte_load) begin
                                        state_nxt = usb_tx_pkg::CRC_HIGH;
                                        data_nxt = ~crc[15:8];
                                end
                        end
                        usb_tx_pkg::CRC_HIGH: begin
                                if (bus.byte_load) begin
                                        state_nxt = usb_tx_pkg::EOP;
                                end
                        end
                        usb_tx_pkg::EOP: begin
                                if (bus.byte_load) begin
                                        state_nxt = usb_tx_pkg::IDLE;
                                end
                        end
                        default: begin
                                state_nxt = usb_tx_pkg::IDLE;
                        end
                endcase
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        state <= usb_tx_pkg::IDLE;
                        crc <= `USB_CRC16_SEED;
                        count <= '0;
                        get_data <= 1'b0;
                        done <= 1'b0;
                end else begin
                        state <= state_nxt;
                        get_data <= fetch;
                        done <= (state == usb_tx_pkg::EOP) && bus.byte_load;
                        if (start && (state == usb_tx_pkg::IDLE)) begin
                                crc <= `USB_CRC16_SEED;
                                count <= size;
                        end else if (fetch) begin
                                crc <= crc16_byte(crc, tx_packet_data);
                                count <= count - 7'd1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                bus.byte_data <= data_nxt;
        end

        a_valid_eop_excl: assert property (@(posedge clk) disable iff (!arst_n)
                !(bus.byte_valid && bus.byte_eop));

        // held until the encoder takes it
        a_data_held: assert property (@(posedge clk) disable iff (!arst_n)
                (bus.byte_valid && !bus.byte_load) |=> $stable(bus.byte_data));

endmodule

`default_nettype wire

// File: verification/usb_tx_tb.sv
`timescale 1ns/10ps
`default_nettype none

module usb_tx_tb;

        localparam int MAX_SIZE = 60;
        localparam int NUM_PKTS = 13;
        localparam int WATCHDOG_CYCLES = 40 * (MAX_SIZE + 5) * NUM_PKTS + 2000;

        // line constants as USB defines them
        localparam usb_tx_pkg::usb_byte_t SYNC_BYTE = 8'h80;
        localparam usb_tx_pkg::usb_byte_t PID_DATA0 = 8'hC3;
        localparam usb_tx_pkg::usb_byte_t PID_ACK = 8'hD2;
        localparam usb_tx_pkg::usb_byte_t PID_NAK = 8'h5A;
        localparam usb_tx_pkg::usb_crc_t CRC_POLY = 16'hA001;
        localparam usb_tx_pkg::usb_crc_t CRC_SEED = 16'hFFFF;

        logic clk;
        logic arst_n;
        usb_tx_pkg::tx_req_t tx_packet;
        usb_tx_pkg::usb_byte_t tx_packet_data;
        usb_tx_pkg::pkt_size_t tx_packet_data_size;
        logic get_data;
        logic busy;
        logic tx_done;
        logic dp;
        logic dm;

        // payload stream consumed in order by get_data
        usb_tx_pkg::usb_byte_t stream [0:4095];
        int stream_wr = 0;
        int fetch_total = 0;
        logic [31:0] rng = 32'd74;

        // expected packets from the reference function
        usb_tx_pkg::usb_byte_t exp_bytes [0:4095];
        int exp_len [0:63];
        usb_tx_pkg::pkt_size_t exp_size [0:63];
        logic exp_data [0:63];
        int exp_wr = 0;
        int pkt_wr = 0;

        // line monitor state
        logic in_pkt = 1'b0;
        logic last_level = 1'b1;
        logic eop_pending = 1'b0;
        int ones_run = 0;
        int bit_pos = 0;
        int se0_cnt = 0;
        usb_tx_pkg::usb_byte_t cur_byte = 8'h00;
        usb_tx_pkg::usb_byte_t rx_q [$];
        usb_tx_pkg::pkt_size_t gd_count = 7'd0;
        int pkt_rd = 0;
        int exp_rd = 0;
        int done_count = 0;

        usb_tx dut (
                .clk                 (clk),
                .arst_n              (arst_n),
                .tx_packet           (tx_packet),
                .tx_packet_data      (tx_packet_data),
                .tx_packet_data_size (tx_packet_data_size),
                .get_data            (get_data),
                .busy                (busy),
                .tx_done             (tx_done),
                .dp                  (dp),
                .dm                  (dm)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        // bit serial crc16 over the payload with the lsb of each byte first
        function automatic usb_tx_pkg::usb_crc_t ref_crc16(input int first, input int size);
                usb_tx_pkg::usb_crc_t r;
                usb_tx_pkg::usb_byte_t b;
                logic fb;
                r = CRC_SEED;
                for (int i = 0; i < size; i++) begin
                        b = stream[first + i];
                        for (int k = 0; k < 8; k++) begin
                                fb = r[0] ^ b[k];
                                r = {1'b0, r[15:1]} ^ (fb ? CRC_POLY : 16'h0000);
                        end
                end
                return r;
        endfunction

        // expected byte list of one packet
        function automatic void build_expected(input usb_tx_pkg::tx_req_t req, input int first,
                                               input int size);
                int base;
                usb_tx_pkg::usb_crc_t crc;
                base = exp_wr;
                exp_bytes[exp_wr] = SYNC_BYTE;
                case (req)
                        2'd1: exp_bytes[exp_wr + 1] = PID_DATA0;
                        2'd2: exp_bytes[exp_wr + 1] = PID_ACK;
                        default: exp_bytes[exp_wr + 1] = PID_NAK;
                endcase
                exp_wr = exp_wr + 2;
                if (req == 2'd1) begin
                        for (int i = 0; i < size; i++) begin
                                exp_bytes[exp_wr] = stream[first + i];
                                exp_wr = exp_wr + 1;
                        end
                        crc = ~ref_crc16(first, size);
                        exp_bytes[exp_wr] = crc[7:0];
                        exp_bytes[exp_wr + 1] = crc[15:8];
                        exp_wr = exp_wr + 2;
                end
                exp_len[pkt_wr] = exp_wr - base;
                exp_size[pkt_wr] = (req == 2'd1) ? usb_tx_pkg::pkt_size_t'(size) : 7'd0;
                exp_data[pkt_wr] = (req == 2'd1);
                pkt_wr++;
        endfunction

        task automatic stop_run();
                $display("TEST FAIL");
                $fatal(1, "simulation stopped at the first error");
        endtask

        task automatic fail_plain(input string msg);
                $display("%s", msg);
                stop_run();
        endtask

        task automatic check_byte(input usb_tx_pkg::usb_byte_t got,
                                  input usb_tx_pkg::usb_byte_t exp, input int idx);
                if (got !== exp) begin
                        $display("FAIL at %0t: packet %0d byte %0d is %h, expected %h",
                                 $time, pkt_rd, idx, got, exp);
                        stop_run();
                end
        endtask

        task automatic check_crc(input usb_tx_pkg::usb_crc_t got, input usb_tx_pkg::usb_crc_t exp);
                if (got !== exp) begin
                        $display("FAIL at %0t: packet %0d crc16 is %h, expected %h",
                                 $time, pkt_rd, got, exp);
                        stop_run();
                end
        endtask

        task automatic check_size(input usb_tx_pkg::pkt_size_t got,
                                  input usb_tx_pkg::pkt_size_t exp, input string what);
                if (got !== exp) begin
                        $display("FAIL at %0t: %s is %0d, expected %0d", $time, what, got, exp);
                        stop_run();
                end
        endtask

        task automatic check_level(input logic got, input logic exp, input string what);
                if (got !== exp) begin
                        $display("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp);
                        stop_run();
                end
        endtask

        // payload source shows the next byte after each get_data
        initial begin
                tx_packet_data = 8'h00;
                forever begin
                        @(posedge clk);
                        if (get_data) begin
                                fetch_total = fetch_total + 1;
                        end
                        tx_packet_data <= stream[fetch_total];
                end
        end

        // compares one finished packet with its expected bytes
        task automatic compare_packet();
                int n;
                n = exp_len[pkt_rd];
                check_size(usb_tx_pkg::pkt_size_t'(rx_q.size()), usb_tx_pkg::pkt_size_t'(n),
                           "bytes in packet");
                check_size(gd_count, exp_size[pkt_rd], "get_data pulses");
                for (int i = 0; i < n; i++) begin
                        if (!(exp_data[pkt_rd] && i >= n - 2)) begin
                                check_byte(rx_q[i], exp_bytes[exp_rd + i], i);
                        end
                end
                if (exp_data[pkt_rd]) begin
                        check_crc({rx_q[n - 1], rx_q[n - 2]},
                                  {exp_bytes[exp_rd + n - 1], exp_bytes[exp_rd + n - 2]});
                end
                exp_rd = exp_rd + n;
        endtask

        always @(posedge clk) begin : line_monitor
                logic level;
                logic line_bit;
                if (arst_n) begin
                        if (tx_done) begin
                                if (!eop_pending || pkt_rd >= pkt_wr) begin
                                        fail_plain("tx_done came without a packet and its EOP");
                                end
                                compare_packet();
                                pkt_rd = pkt_rd + 1;
                                done_count = done_count + 1;
                                eop_pending = 1'b0;
                                gd_count = 7'd0;
                        end
                        if (get_data) begin
                                gd_count = gd_count + 7'd1;
                        end
                        if (dp && dm) begin
                                fail_plain("both dp and dm were high on the line");
                        end
                        level = dp;
                        if (!in_pkt && !dp && !dm) begin
                                fail_plain("SE0 seen on the line outside a packet");
                        end
                        // first K after idle J opens a packet
                        if (!in_pkt && !level) begin
                                in_pkt = 1'b1;
                                ones_run = 0;
                                bit_pos = 0;
                                se0_cnt = 0;
                                rx_q.delete();
                        end
                        if (in_pkt) begin
                                if (!dp && !dm) begin
                                        se0_cnt = se0_cnt + 1;
                                end else if (se0_cnt != 0) begin
                                        if (se0_cnt != 2 || !level || bit_pos != 0) begin
                                                fail_plain("malformed EOP on the line");
                                        end
                                        in_pkt = 1'b0;
                                        eop_pending = 1'b1;
                                        se0_cnt = 0;
                                        last_level = 1'b1;
                                end else begin
                                        // nrzi decode where no change is a one
                                        line_bit = (level == last_level);
                                        last_level = level;
                                        if (ones_run == 6) begin
                                                if (line_bit) begin
                                                        fail_plain("seven ones in a row");
                                                end
                                                ones_run = 0;
                                        end else begin
                                                ones_run = line_bit ? ones_run + 1 : 0;
                                                cur_byte = {line_bit, cur_byte[7:1]};
                                                bit_pos = bit_pos + 1;
                                                if (bit_pos == 8) begin
                                                        rx_q.push_back(cur_byte);
                                                        bit_pos = 0;
                                                end
                                        end
                                end
                        end
                end
        end

        // one request that is optionally poked again while busy
        task automatic send_packet(input usb_tx_pkg::tx_req_t req, input int size,
                                   input logic ones, input logic poke);
                int first;
                first = stream_wr;
                if (req == 2'd1) begin
                        for (int i = 0; i < size; i++) begin
                                rng = xorshift32(rng);
                                stream[stream_wr] = ones ? 8'hFF : rng[7:0];
                                stream_wr = stream_wr + 1;
                        end
                end
                build_expected(req, first, size);
                @(posedge clk);
                tx_packet <= req;
                tx_packet_data_size <= usb_tx_pkg::pkt_size_t'(size);
                @(posedge clk);
                tx_packet <= 2'd0;
                @(posedge clk);
                check_level(busy, 1'b1, "busy after an accepted request");
                if (poke) begin
                        tx_packet <= 2'd3;
                        tx_packet_data_size <= 7'd9;
                        @(posedge clk);
                        tx_packet <= 2'd0;
                end
                while (done_count < pkt_wr) begin
                        @(posedge clk);
                end
                repeat (2) @(posedge clk);
        endtask

        initial begin
                arst_n = 1'b0;
                tx_packet = 2'd0;
                tx_packet_data_size = 7'd0;
                repeat (4) @(posedge clk);
                arst_n <= 1'b1;
                @(posedge clk);
                @(posedge clk);
                check_level(dp, 1'b1, "dp after reset");
                check_level(dm, 1'b0, "dm after reset");
                check_level(busy, 1'b0, "busy after reset");
                check_level(tx_done, 1'b0, "tx_done after reset");
                check_level(get_data, 1'b0, "get_data after reset");
                send_packet(2'd2, 0, 1'b0, 1'b0);
                send_packet(2'd3, 0, 1'b0, 1'b1);
                send_packet(2'd1, 0, 1'b0, 1'b0);
                send_packet(2'd1, 24, 1'b1, 1'b1);
                send_packet(2'd1, 7, 1'b1, 1'b0);
                for (int p = 0; p < NUM_PKTS - 5; p++) begin
                        rng = xorshift32(rng);
                        send_packet(2'd1, int'(rng % 32'd61), 1'b0, p[0]);
                end
                // room for a stray packet to show up
                repeat (50) @(posedge clk);
                if (done_count != pkt_wr || in_pkt || busy) begin
                        fail_plain("a request made while busy led to an extra packet");
                end else begin
                        $display("TEST PASS");
                        $finish;
                end
        end

        initial begin
                repeat (WATCHDOG_CYCLES) @(posedge clk);
                fail_plain("watchdog expired because the transmitter never finished its packets");
        end

endmodule

`default_nettype wire
